// ==== bench/tb_pkt_rx.sv ====
// Packet receiver testbench
// Sends serial packets into pkt_rx_top, reads them back over AXI4-Lite and
// checks every read response against a queue of expected values.

`timescale 1ns/1ps

module tb_pkt_rx;

    localparam logic [7:0] CHIP_ID   = 8'h5A;
    localparam int         FRAME_MAX = 400;
    localparam int         AXI_MAX   = 40;

    logic        clk_rx;
    logic        reset_n;
    logic        rx_in;
    logic        v3_mode;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // scoreboard with one entry per AXI read in issue order
    logic [31:0] exp_q [$];
    logic [31:0] exp_head;

    int seed = 32'h383b;
    int err_cnt;
    int err_mark;
    int test_cnt;
    int fail_cnt;

    logic [62:0]        pkt;
    logic [62:0]        burst [6];
    logic [31:0]        cfg_val;
    pkt_pkg::pkt_cfg_t  reply;

    pkt_rx_top #(
        .CHIP_ID    (CHIP_ID),
        .FIFO_DEPTH (4)
    ) UUT (
        .clk_rx  (clk_rx),
        .reset_n (reset_n),
        .rx_in   (rx_in),
        .v3_mode (v3_mode),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk_rx = 1'b0;
        forever #10 clk_rx = ~clk_rx;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // every accepted read response against the scoreboard head
    a_rdata : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        rvalid && rready |-> rdata == exp_head
    ) else begin
        $display("MISMATCH time=%0t signal=rdata expected=%h actual=%h", $time, exp_head, rdata);
        err_cnt++;
    end

    a_rresp : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        rvalid |-> rresp == 2'b00
    ) else begin
        $display("MISMATCH time=%0t signal=rresp expected=0 actual=%h", $time, rresp);
        err_cnt++;
    end

    a_bresp : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        bvalid |-> bresp == 2'b00
    ) else begin
        $display("MISMATCH time=%0t signal=bresp expected=0 actual=%h", $time, bresp);
        err_cnt++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet building and serial driver
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [62:0] rand_word();
        logic [63:0] r;
        r[31:0]  = $random(seed);
        r[63:32] = $random(seed);
        return r[62:0];
    endfunction

    function automatic logic [62:0] make_data(input logic [7:0] chip, input logic [1:0] decl);
        pkt_pkg::pkt_data_t d;
        d         = rand_word();
        d.chip_id = chip;
        d.decl    = decl;
        return d;
    endfunction

    function automatic logic [62:0] make_cfg(input logic [1:0] decl, input logic [7:0] addr,
                                             input logic [31:0] value);
        pkt_pkg::pkt_cfg_t c;
        c           = rand_word();
        c.chip_id   = CHIP_ID;
        c.decl      = decl;
        c.reg_addr  = addr;
        c.reg_value = value;
        return c;
    endfunction

    // STATUS layout with empty in bit 0 and count in bits 15:8
    function automatic logic [31:0] status_word(input int cnt, input logic is_empty);
        return {16'd0, 8'(cnt), 7'd0, is_empty};
    endfunction

    // start 0, payload LSB first, odd parity, stop 1
    task automatic send_pkt(input logic [62:0] payload, input logic flip_par);
        logic [65:0] line_bits;
        int          cpb;
        line_bits = {1'b1, ~(^payload) ^ flip_par, payload, 1'b0};
        cpb       = v3_mode ? 1 : 2;
        for (int i = 0; i < 66; i++) begin
            repeat (cpb) begin
                @(posedge clk_rx);
                rx_in <= line_bits[i];
            end
        end
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        @(posedge clk_rx);
        while (!UUT.frame_valid && n < FRAME_MAX) begin
            @(posedge clk_rx);
            n++;
        end
        if (!UUT.frame_valid) begin
            $display("TIMEOUT: receiver gave no frame_valid within %0d cycles", FRAME_MAX);
            err_cnt++;
        end
        // router output one cycle later and FIFO head one more
        repeat (2) @(posedge clk_rx);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////////////////////

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk_rx);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        n = 0;
        @(posedge clk_rx);
        while (!(awready && wready) && n < AXI_MAX) begin
            @(posedge clk_rx);
            n++;
        end
        if (!(awready && wready)) begin
            $display("TIMEOUT: write to %h was never accepted on both AW and W", addr);
            err_cnt++;
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(posedge clk_rx);
        while (!bvalid && n < AXI_MAX) begin
            @(posedge clk_rx);
            n++;
        end
        if (!bvalid) begin
            $display("TIMEOUT: write to %h got no response", addr);
            err_cnt++;
        end
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr);
        int          n;
        logic [31:0] nxt;
        @(posedge clk_rx);
        if (exp_q.size() == 0) begin
            $display("ERROR: read of %h issued with no expected value queued", addr);
            err_cnt++;
        end else begin
            nxt = exp_q.pop_front();
            exp_head <= nxt;
        end
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        n = 0;
        @(posedge clk_rx);
        while (!arready && n < AXI_MAX) begin
            @(posedge clk_rx);
            n++;
        end
        if (!arready) begin
            $display("TIMEOUT: read of %h was never accepted", addr);
            err_cnt++;
        end
        arvalid <= 1'b0;
        n = 0;
        @(posedge clk_rx);
        while (!rvalid && n < AXI_MAX) begin
            @(posedge clk_rx);
            n++;
        end
        if (!rvalid) begin
            $display("TIMEOUT: read of %h returned no data", addr);
            err_cnt++;
        end
        rready <= 1'b0;
        // let the rdata check of this edge complete
        @(posedge clk_rx);
    endtask

    // low word first since the PKT_HI read pops
    task automatic expect_pkt(input logic [62:0] p);
        exp_q.push_back(p[31:0]);
        exp_q.push_back({1'b0, p[62:32]});
    endtask

    task automatic read_pkt();
        axi_read(pkt_pkg::ADDR_PKT_LO);
        axi_read(pkt_pkg::ADDR_PKT_HI);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark) begin
            fail_cnt++;
            $display("test %0d %s: fail, %0d errors", test_cnt, name, err_cnt - err_mark);
        end else begin
            $display("test %0d %s: pass", test_cnt, name);
        end
        err_mark = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        err_cnt  = 0;
        err_mark = 0;
        test_cnt = 0;
        fail_cnt = 0;
        exp_head = '0;
        reset_n  <= 1'b0;
        rx_in    <= 1'b1;
        v3_mode  <= 1'b1;
        awaddr   <= '0;
        awvalid  <= 1'b0;
        wdata    <= '0;
        wstrb    <= '0;
        wvalid   <= 1'b0;
        bready   <= 1'b0;
        araddr   <= '0;
        arvalid  <= 1'b0;
        rready   <= 1'b0;
        repeat (16) @(posedge clk_rx);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk_rx);

        // v3 data packet read back whole and FIFO empty afterwards
        pkt = make_data(CHIP_ID, pkt_pkg::DECL_DATA);
        send_pkt(pkt, 1'b0);
        wait_frame();
        expect_pkt(pkt);
        exp_q.push_back(status_word(0, 1'b1));
        read_pkt();
        axi_read(pkt_pkg::ADDR_STATUS);
        end_test("v3 data readback");

        // inverted parity is counted and never queued
        pkt = make_data(CHIP_ID, pkt_pkg::DECL_TEST);
        send_pkt(pkt, 1'b1);
        wait_frame();
        exp_q.push_back(status_word(0, 1'b1));
        exp_q.push_back(32'd1);
        exp_q.push_back(32'd0);
        axi_read(pkt_pkg::ADDR_STATUS);
        axi_read(pkt_pkg::ADDR_PAR_CNT);
        axi_write(pkt_pkg::ADDR_PAR_CNT, 32'd0);
        axi_read(pkt_pkg::ADDR_PAR_CNT);
        end_test("parity error");

        // foreign chip id dropped silently while the broadcast id is kept
        send_pkt(make_data(8'h33, pkt_pkg::DECL_DATA), 1'b0);
        wait_frame();
        exp_q.push_back(status_word(0, 1'b1));
        axi_read(pkt_pkg::ADDR_STATUS);
        pkt = make_data(pkt_pkg::BROADCAST_ID, pkt_pkg::DECL_DATA);
        send_pkt(pkt, 1'b0);
        wait_frame();
        exp_q.push_back(status_word(1, 1'b0));
        expect_pkt(pkt);
        axi_read(pkt_pkg::ADDR_STATUS);
        read_pkt();
        end_test("chip id filter");

        // config write to word 2 then a read request answered from the bank
        cfg_val = $random(seed);
        send_pkt(make_cfg(pkt_pkg::DECL_CFG_WR, 8'd2, cfg_val), 1'b0);
        wait_frame();
        pkt = make_cfg(pkt_pkg::DECL_CFG_RD, 8'd2, $random(seed));
        send_pkt(pkt, 1'b0);
        wait_frame();
        reply           = pkt;
        reply.reg_value = cfg_val;
        exp_q.push_back(cfg_val);
        expect_pkt(reply);
        axi_read(pkt_pkg::ADDR_CFG_BASE + 8'd8);
        read_pkt();
        end_test("config write and read");

        // v2 line timing with two clocks per bit
        @(posedge clk_rx);
        v3_mode <= 1'b0;
        @(posedge clk_rx);
        pkt = make_data(CHIP_ID, pkt_pkg::DECL_DATA);
        send_pkt(pkt, 1'b0);
        wait_frame();
        expect_pkt(pkt);
        exp_q.push_back(status_word(0, 1'b1));
        read_pkt();
        axi_read(pkt_pkg::ADDR_STATUS);
        @(posedge clk_rx);
        v3_mode <= 1'b1;
        @(posedge clk_rx);
        end_test("v2 data readback");

        // six packets into a four deep FIFO where the last two are dropped
        for (int k = 0; k < 6; k++) begin
            burst[k] = make_data(CHIP_ID, pkt_pkg::DECL_DATA);
            send_pkt(burst[k], 1'b0);
            wait_frame();
        end
        exp_q.push_back(status_word(4, 1'b0));
        exp_q.push_back(32'd2);
        for (int k = 0; k < 4; k++) begin
            expect_pkt(burst[k]);
        end
        exp_q.push_back(status_word(0, 1'b1));
        axi_read(pkt_pkg::ADDR_STATUS);
        axi_read(pkt_pkg::ADDR_DROP_CNT);
        for (int k = 0; k < 4; k++) begin
            read_pkt();
        end
        axi_read(pkt_pkg::ADDR_STATUS);
        end_test("FIFO overflow");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/axil_readout.sv ====
// AXI4-Lite readout port
// Register map for FIFO status, packet head, parity and drop counters and
// the configuration bank. A PKT_HI read pops the FIFO. Writes only clear
// the two counters, every write is answered OKAY.

`timescale 1ns/1ps

module axil_readout #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk_rx,
    input  logic                        reset_n,
    // write address, data and response
    input  logic [7:0]                  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    // read address and data
    input  logic [7:0]                  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // FIFO and router side
    input  pkt_pkg::pkt_word_u          head,
    input  logic                        empty,
    input  logic [$clog2(FIFO_DEPTH):0] count,
    output logic                        pop,
    input  pkt_pkg::cfg_bank_t          cfg,
    input  logic                        par_err,
    input  logic                        drop
);

    logic        ar_hs;
    logic        wr_hs;
    logic        clr_par;
    logic        clr_drop;
    logic [31:0] rd_mux;
    logic [15:0] par_cnt;
    logic [15:0] drop_cnt;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // one read outstanding at a time
    assign arready = !rvalid;
    assign ar_hs   = arvalid && arready;
    assign pop     = ar_hs && (araddr == pkt_pkg::ADDR_PKT_HI) && !empty;

    // address and data accepted together, wdata itself carries no meaning
    assign awready  = awvalid && wvalid && !bvalid;
    assign wready   = awready;
    assign wr_hs    = awready;
    assign clr_par  = wr_hs && (awaddr == pkt_pkg::ADDR_PAR_CNT) && (|wstrb);
    assign clr_drop = wr_hs && (awaddr == pkt_pkg::ADDR_DROP_CNT) && (|wstrb);

    ////////////////////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (araddr)
            pkt_pkg::ADDR_STATUS:   rd_mux = {16'd0, 8'(count), 7'd0, empty};
            pkt_pkg::ADDR_PKT_LO:   rd_mux = head[31:0];
            pkt_pkg::ADDR_PKT_HI:   rd_mux = empty ? 32'd0 : {1'b0, head[62:32]};
            pkt_pkg::ADDR_PAR_CNT:  rd_mux = {16'd0, par_cnt};
            pkt_pkg::ADDR_DROP_CNT: rd_mux = {16'd0, drop_cnt};
            default: begin
                // cfg words at 0x20 to 0x2C
                if (araddr[7:4] == pkt_pkg::ADDR_CFG_BASE[7:4] && araddr[1:0] == 2'b00) begin
                    rd_mux = cfg[araddr[3:2]];
                end
            end
        endcase
    end

    always_ff @(posedge clk_rx or negedge reset_n) begin
        if (!reset_n) begin
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            par_cnt  <= 16'd0;
            drop_cnt <= 16'd0;
        end else begin
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // clear wins over a simultaneous event, counters wrap
            if (clr_par) begin
                par_cnt <= 16'd0;
            end else if (par_err) begin
                par_cnt <= par_cnt + 16'd1;
            end
            if (clr_drop) begin
                drop_cnt <= 16'd0;
            end else if (drop) begin
                drop_cnt <= drop_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_rx) begin
        if (ar_hs) begin
            rdata <= rd_mux;
        end
    end

    // read response held until the master takes it
    a_rvalid_hold : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

// ==== hdl/pkt_fifo.sv ====
// Readout FIFO
// Circular buffer of 63 bit packets with read and write pointers and an
// occupancy count. Head shows the oldest entry without popping it.

`timescale 1ns/1ps

module pkt_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clk_rx,
    input  logic                          reset_n,
    input  logic                          push,
    input  pkt_pkg::pkt_word_u            push_word,
    input  logic                          pop,
    output pkt_pkg::pkt_word_u            head,
    output logic                          empty,
    output logic                          full,
    output logic [$clog2(FIFO_DEPTH):0]   count
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;

    pkt_pkg::pkt_word_u mem [FIFO_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic               push_ok;
    logic               pop_ok;

    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;
    assign head    = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == CW'(FIFO_DEPTH));

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_rx or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + AW'(1);
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + AW'(1);
            end
            if (push_ok && !pop_ok) begin
                count <= count + CW'(1);
            end else if (pop_ok && !push_ok) begin
                count <= count - CW'(1);
            end
        end
    end

    always_ff @(posedge clk_rx) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // readout only pops on a non empty FIFO
    a_no_pop_empty : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        pop |-> !empty
    );

endmodule

// ==== hdl/pkt_pkg.sv ====
// Packet receiver shared definitions
// Packet layouts for the data and configuration views of a received word,
// the frame passed from the serial receiver to the router, the configuration
// bank, packet declarations and the AXI4-Lite register map.

package pkt_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // packet views, 63 payload bits, MSB first
    ////////////////////////////////////////////////////////////////////////////

    // data and test packets
    typedef struct packed {
        logic        downstream;
        logic [1:0]  shared_fifo;
        logic [1:0]  local_fifo;
        logic [1:0]  trig_type;
        logic [7:0]  adc;
        logic [31:0] timestamp;
        logic [5:0]  channel_id;
        logic [7:0]  chip_id;
        logic [1:0]  decl;
    } pkt_data_t;

    // configuration write and read packets
    typedef struct packed {
        logic        downstream;
        logic [11:0] reserved;
        logic [31:0] reg_value;
        logic [7:0]  reg_addr;
        logic [7:0]  chip_id;
        logic [1:0]  decl;
    } pkt_cfg_t;

    // one received word, decoded by its declaration field
    typedef union packed {
        pkt_data_t data;
        pkt_cfg_t  cfg;
    } pkt_word_u;

    // receiver output, payload plus parity check result
    typedef struct packed {
        pkt_word_u word;
        logic      parity_ok;
    } rx_frame_t;

    // four 32 bit configuration words
    typedef logic [3:0][31:0] cfg_bank_t;

    ////////////////////////////////////////////////////////////////////////////
    // declarations and ids
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [1:0] DECL_DATA   = 2'b00;
    localparam logic [1:0] DECL_TEST   = 2'b01;
    localparam logic [1:0] DECL_CFG_WR = 2'b10;
    localparam logic [1:0] DECL_CFG_RD = 2'b11;

    localparam logic [7:0] BROADCAST_ID = 8'hFF;

    // AXI4-Lite byte addresses
    localparam logic [7:0] ADDR_STATUS   = 8'h00;
    localparam logic [7:0] ADDR_PKT_LO   = 8'h04;
    localparam logic [7:0] ADDR_PKT_HI   = 8'h08;
    localparam logic [7:0] ADDR_PAR_CNT  = 8'h0C;
    localparam logic [7:0] ADDR_DROP_CNT = 8'h10;
    localparam logic [7:0] ADDR_CFG_BASE = 8'h20;

endpackage

// ==== hdl/pkt_router.sv ====
// Packet router
// Drops frames with bad parity or a foreign chip id, applies configuration
// writes to the four word bank, turns configuration reads into reply
// packets and pushes data, test and reply packets into the readout FIFO.
// All outputs are registered one cycle after frame_valid.

`timescale 1ns/1ps

module pkt_router #(
    parameter logic [7:0] CHIP_ID = 8'h01
) (
    input  logic               clk_rx,
    input  logic               reset_n,
    input  pkt_pkg::rx_frame_t frame,
    input  logic               frame_valid,
    input  logic               full,
    output logic               push,
    output pkt_pkg::pkt_word_u push_word,
    output pkt_pkg::cfg_bank_t cfg,
    output logic               par_err,
    output logic               drop
);

    logic               id_match;
    logic               accept;
    logic               cfg_wr;
    logic               want_push;
    pkt_pkg::pkt_word_u next_word;

    // chip id sits at the same place in both views
    assign id_match  = (frame.word.data.chip_id == CHIP_ID) ||
                       (frame.word.data.chip_id == pkt_pkg::BROADCAST_ID);
    assign accept    = frame_valid && frame.parity_ok && id_match;
    assign cfg_wr    = accept && (frame.word.cfg.decl == pkt_pkg::DECL_CFG_WR);
    // data, test and config read all end up in the FIFO
    assign want_push = accept && (frame.word.cfg.decl != pkt_pkg::DECL_CFG_WR);

    // reply copies the request, value field taken from the bank
    always_comb begin
        next_word = frame.word;
        if (frame.word.cfg.decl == pkt_pkg::DECL_CFG_RD) begin
            next_word.cfg.reg_value = cfg[frame.word.cfg.reg_addr[1:0]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_rx or negedge reset_n) begin
        if (!reset_n) begin
            push    <= 1'b0;
            drop    <= 1'b0;
            par_err <= 1'b0;
            cfg     <= '0;
        end else begin
            push    <= want_push && !full;
            // overflow, packet lost and counted by the readout
            drop    <= want_push && full;
            par_err <= frame_valid && !frame.parity_ok;
            if (cfg_wr) begin
                cfg[frame.word.cfg.reg_addr[1:0]] <= frame.word.cfg.reg_value;
            end
        end
    end

    always_ff @(posedge clk_rx) begin
        if (want_push) begin
            push_word <= next_word;
        end
    end

    // full can only fall between frame_valid and push, the FIFO never overflows
    a_no_push_full : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        push |-> !full
    );

endmodule

// ==== hdl/pkt_rx_top.sv ====
// Packet receiver top level
// Serial receiver, router, readout FIFO and AXI4-Lite register port.

`timescale 1ns/1ps

module pkt_rx_top #(
    parameter logic [7:0] CHIP_ID    = 8'h01,
    parameter int         FIFO_DEPTH = 8
) (
    input  logic        clk_rx,
    input  logic        reset_n,
    input  logic        rx_in,
    // static strap, high for one clock per bit
    input  logic        v3_mode,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    pkt_pkg::rx_frame_t          frame;
    logic                        frame_valid;
    logic                        push;
    pkt_pkg::pkt_word_u          push_word;
    logic                        full;
    pkt_pkg::pkt_word_u          head;
    logic                        empty;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic                        pop;
    pkt_pkg::cfg_bank_t          cfg;
    logic                        par_err;
    logic                        drop;

    uart_pkt_rx u_rx (
        .clk_rx      (clk_rx),
        .reset_n     (reset_n),
        .rx_in       (rx_in),
        .v3_mode     (v3_mode),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    pkt_router #(
        .CHIP_ID (CHIP_ID)
    ) u_router (
        .clk_rx      (clk_rx),
        .reset_n     (reset_n),
        .frame       (frame),
        .frame_valid (frame_valid),
        .full        (full),
        .push        (push),
        .push_word   (push_word),
        .cfg         (cfg),
        .par_err     (par_err),
        .drop        (drop)
    );

    pkt_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_rx    (clk_rx),
        .reset_n   (reset_n),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    axil_readout #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_axil (
        .clk_rx   (clk_rx),
        .reset_n  (reset_n),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .head     (head),
        .empty    (empty),
        .count    (count),
        .pop      (pop),
        .cfg      (cfg),
        .par_err  (par_err),
        .drop     (drop)
    );

endmodule

// ==== hdl/uart_pkt_rx.sv ====
// Serial packet receiver
// Synchronizes the asynchronous line, finds the start bit, shifts in
// 63 payload bits plus the parity bit LSB first and checks odd parity.
// v3 mode samples every clock, v2 mode samples the second of two clocks
// per bit. A finished frame is flagged by a single cycle frame_valid.

`timescale 1ns/1ps

module uart_pkt_rx (
    input  logic               clk_rx,
    input  logic               reset_n,
    input  logic               rx_in,
    input  logic               v3_mode,
    output pkt_pkg::rx_frame_t frame,
    output logic               frame_valid
);

    // two flop synchronizer
    logic rx_d1;
    logic rx_d2;

    // receive control
    logic       busy;
    logic       phase;
    logic [6:0] bit_cnt;
    logic       sample;
    logic       last_bit;

    // shift register, bit 0 arrives first and ends at the LSB
    logic [63:0] shift_reg;
    logic [63:0] shift_next;

    // v2 samples only when phase is set, i.e. on the second clock of a bit
    assign sample     = busy && (v3_mode || phase);
    assign shift_next = {rx_d2, shift_reg[63:1]};
    // bit 64 is the parity bit
    assign last_bit   = sample && (bit_cnt == 7'd64);

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_rx or negedge reset_n) begin
        if (!reset_n) begin
            rx_d1       <= 1'b1;
            rx_d2       <= 1'b1;
            busy        <= 1'b0;
            phase       <= 1'b0;
            bit_cnt     <= 7'd0;
            frame_valid <= 1'b0;
        end else begin
            rx_d1       <= rx_in;
            rx_d2       <= rx_d1;
            frame_valid <= last_bit;
            if (!busy) begin
                // first synchronized low while idle is the start bit
                if (!rx_d2) begin
                    busy  <= 1'b1;
                    phase <= 1'b1;
                    // v3 has already seen the start bit here, v2 samples it once more
                    bit_cnt <= v3_mode ? 7'd1 : 7'd0;
                end
            end else begin
                phase <= ~phase;
                if (sample) begin
                    bit_cnt <= bit_cnt + 7'd1;
                end
                // back to idle during the stop bit, new start bits ignored until then
                if (last_bit) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    // in v2 mode the extra start bit sample is shifted out by the 65th shift
    always_ff @(posedge clk_rx) begin
        if (sample) begin
            shift_reg <= shift_next;
        end
        if (last_bit) begin
            frame.word      <= shift_next[62:0];
            // odd parity over payload and parity bit
            frame.parity_ok <= ^shift_next;
        end
    end

    // frames are at least 65 cycles apart
    a_valid_pulse : assert property (
        @(posedge clk_rx) disable iff (!reset_n)
        frame_valid |=> !frame_valid
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the packet receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_pkt_rx -f sources.f -o tb_pkt_rx \
    > sim.log 2>&1 \
    && ./obj_dir/tb_pkt_rx >> sim.log 2>&1 \
    || { cat sim.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
exit 0

// ==== sources.f ====
hdl/pkt_pkg.sv
hdl/uart_pkt_rx.sv
hdl/pkt_router.sv
hdl/pkt_fifo.sv
hdl/axil_readout.sv
hdl/pkt_rx_top.sv
bench/tb_pkt_rx.sv
